//--- design/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

`define CORE_RESET_PC 32'hbfc0_0000
`define CORE_XLEN     32
`define CORE_REG_AW   5

// major opcodes
`define OP_SPECIAL 6'b000000
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDIU   6'b001001
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

// funct field of SPECIAL
`define FN_ADDU    6'b100001
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_SLT     6'b101010

`endif

//--- design/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_idx_t;
    typedef logic [`CORE_XLEN-1:0]   instr_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_state_e;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        word_t       pc;
        alu_op_e     alu_op;
        word_t       op_a;       // rs value
        word_t       op_b;       // rt value or immediate
        word_t       store_data;
        reg_idx_t    dst;
        logic        reg_write;
        logic        mem_read;
        logic        mem_write;
        logic        is_branch;
        logic        branch_ne;  // BNE when set, BEQ otherwise
        logic [15:0] br_offset;  // word offset, not yet shifted
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;        // ALU value or memory address
        word_t    store_data;
        reg_idx_t dst;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;
        reg_idx_t dst;
        logic     reg_write;
    } mem_wb_t;

    // producer in a later stage, as seen from decode
    typedef struct packed {
        logic     valid;         // writes a nonzero register
        reg_idx_t dst;
        word_t    value;
        logic     is_load;
    } fwd_t;

endpackage

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

`include "core_cfg.svh"

module decode_stage (
    input  logic              aclk,
    input  logic              rst,
    input  logic              id_wr,
    input  logic              id_flush,
    input  core_pkg::if_id_t  if_id,
    input  core_pkg::fwd_t    ex_fwd,
    input  core_pkg::fwd_t    mem_fwd,
    input  core_pkg::mem_wb_t wb,
    output core_pkg::id_ex_t  id_ex,
    output logic              load_stall
);
    import core_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    word_t       rs_rf;
    word_t       rt_rf;
    word_t       rs_val;
    word_t       rt_val;
    word_t       imm_ext;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        sign_ext;
    logic        uses_rs;
    logic        uses_rt;
    logic        dst_rt;     // I-type writes rt instead of rd
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    logic        is_branch;
    logic        branch_ne;
    id_ex_t      id_ex_nxt;

    function automatic word_t fwd_pick(reg_idx_t idx, word_t rf_val, fwd_t ex_f, fwd_t mem_f);
        if (ex_f.valid && !ex_f.is_load && ex_f.dst == idx) begin
            return ex_f.value;
        end else if (mem_f.valid && !mem_f.is_load && mem_f.dst == idx) begin
            return mem_f.value;
        end
        return rf_val;
    endfunction

    function automatic logic load_hit(reg_idx_t idx, fwd_t f);
        return f.valid && f.is_load && f.dst == idx;
    endfunction

    assign opcode = if_id.instr[31:26];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign funct  = if_id.instr[5:0];
    assign imm    = if_id.instr[15:0];

    reg_file u_reg_file (
        .aclk    (aclk),
        .rst     (rst),
        .wb      (wb),
        .ra_idx  (rs),
        .rb_idx  (rt),
        .ra_data (rs_rf),
        .rb_data (rt_rf)
    );

    always_comb begin
        alu_op    = ADD;
        use_imm   = 1'b0;
        sign_ext  = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b0;
        dst_rt    = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        is_branch = 1'b0;
        branch_ne = 1'b0;
        case (opcode)
            `OP_SPECIAL: begin
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    `FN_ADDU: alu_op = ADD;
                    `FN_SUBU: alu_op = SUB;
                    `FN_AND:  alu_op = AND;
                    `FN_OR:   alu_op = OR;
                    `FN_XOR:  alu_op = XOR;
                    `FN_SLT:  alu_op = SLT;
                    default:  reg_write = 1'b0;  // nop and unsupported
                endcase
            end
            `OP_ADDIU: begin
                use_imm   = 1'b1;
                dst_rt    = 1'b1;
                reg_write = 1'b1;
            end
            `OP_ORI: begin
                alu_op    = OR;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
                dst_rt    = 1'b1;
                reg_write = 1'b1;
            end
            `OP_LUI: begin
                alu_op    = LUI;
                use_imm   = 1'b1;
                sign_ext  = 1'b0;
                uses_rs   = 1'b0;
                dst_rt    = 1'b1;
                reg_write = 1'b1;
            end
            `OP_LW: begin
                use_imm   = 1'b1;
                dst_rt    = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            `OP_SW: begin
                use_imm   = 1'b1;
                uses_rt   = 1'b1;
                mem_write = 1'b1;
            end
            `OP_BEQ, `OP_BNE: begin
                uses_rt   = 1'b1;
                is_branch = 1'b1;
                branch_ne = (opcode == `OP_BNE);
            end
            default: uses_rs = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'h0000, imm};
    assign rs_val  = fwd_pick(rs, rs_rf, ex_fwd, mem_fwd);
    assign rt_val  = fwd_pick(rt, rt_rf, ex_fwd, mem_fwd);

    // load result not ready before MEM/WB, so wait
    assign load_stall = if_id.valid &&
                        ((uses_rs && (load_hit(rs, ex_fwd) || load_hit(rs, mem_fwd))) ||
                         (uses_rt && (load_hit(rt, ex_fwd) || load_hit(rt, mem_fwd))));

    always_comb begin
        id_ex_nxt.valid      = if_id.valid;
        id_ex_nxt.pc         = if_id.pc;
        id_ex_nxt.alu_op     = alu_op;
        id_ex_nxt.op_a       = rs_val;
        id_ex_nxt.op_b       = use_imm ? imm_ext : rt_val;
        id_ex_nxt.store_data = rt_val;
        id_ex_nxt.dst        = dst_rt ? rt : rd;
        id_ex_nxt.reg_write  = reg_write;
        id_ex_nxt.mem_read   = mem_read;
        id_ex_nxt.mem_write  = mem_write;
        id_ex_nxt.is_branch  = is_branch;
        id_ex_nxt.branch_ne  = branch_ne;
        id_ex_nxt.br_offset  = imm;
    end

    always_ff @(posedge aclk) begin
        if (id_wr) begin
            id_ex <= id_ex_nxt;
        end
        if (rst || id_flush) begin
            id_ex.valid <= 1'b0;     // bubble
        end
    end

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`default_nettype none

module execute_stage (
    input  logic              aclk,
    input  logic              rst,
    input  logic              ex_wr,
    input  core_pkg::id_ex_t  id_ex,
    output core_pkg::ex_mem_t ex_mem,
    output core_pkg::fwd_t    ex_fwd,
    output logic              branch_taken,
    output core_pkg::word_t   branch_target
);
    import core_pkg::*;

    word_t   alu_res;
    word_t   br_disp;
    logic    ops_equal;
    ex_mem_t ex_mem_nxt;

    always_comb begin
        case (id_ex.alu_op)
            ADD:     alu_res = id_ex.op_a + id_ex.op_b;
            SUB:     alu_res = id_ex.op_a - id_ex.op_b;
            AND:     alu_res = id_ex.op_a & id_ex.op_b;
            OR:      alu_res = id_ex.op_a | id_ex.op_b;
            XOR:     alu_res = id_ex.op_a ^ id_ex.op_b;
            SLT:     alu_res = {31'd0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
            LUI:     alu_res = {id_ex.op_b[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    // target relative to the delay slot
    assign br_disp       = {{14{id_ex.br_offset[15]}}, id_ex.br_offset, 2'b00};
    assign branch_target = id_ex.pc + 32'd4 + br_disp;
    assign ops_equal     = (id_ex.op_a == id_ex.op_b);
    assign branch_taken  = id_ex.valid && id_ex.is_branch && (ops_equal != id_ex.branch_ne);

    // result heading into EX/MEM, seen by decode
    assign ex_fwd.valid   = id_ex.valid && id_ex.reg_write && (id_ex.dst != '0);
    assign ex_fwd.dst     = id_ex.dst;
    assign ex_fwd.value   = alu_res;
    assign ex_fwd.is_load = id_ex.mem_read;

    always_comb begin
        ex_mem_nxt.valid      = id_ex.valid;
        ex_mem_nxt.pc         = id_ex.pc;
        ex_mem_nxt.result     = alu_res;
        ex_mem_nxt.store_data = id_ex.store_data;
        ex_mem_nxt.dst        = id_ex.dst;
        ex_mem_nxt.reg_write  = id_ex.reg_write;
        ex_mem_nxt.mem_read   = id_ex.mem_read;
        ex_mem_nxt.mem_write  = id_ex.mem_write;
    end

    always_ff @(posedge aclk) begin
        if (ex_wr) begin
            ex_mem <= ex_mem_nxt;
        end
        if (rst) begin
            ex_mem.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/fetch_stage.sv
`default_nettype none

`include "core_cfg.svh"

module fetch_stage (
    input  logic              aclk,
    input  logic              rst,
    input  logic              pc_wr,
    input  logic              if_wr,
    input  logic              if_flush,
    input  logic              branch_taken,
    input  core_pkg::word_t   branch_target,
    input  core_pkg::instr_t  imem_rdata,
    output core_pkg::word_t   imem_addr,
    output core_pkg::if_id_t  if_id
);
    import core_pkg::*;

    word_t pc;
    word_t pc_nxt;

    assign imem_addr = pc;               // ROM answers in the same cycle
    assign pc_nxt    = branch_taken ? branch_target : pc + 32'd4;

    always_ff @(posedge aclk) begin
        if (rst) begin
            pc <= `CORE_RESET_PC;
        end else if (pc_wr) begin
            pc <= pc_nxt;
        end
    end

    always_ff @(posedge aclk) begin
        if (if_wr) begin
            if_id.pc    <= pc;
            if_id.instr <= imem_rdata;
        end
        if (rst || if_flush) begin
            if_id.valid <= 1'b0;
        end else if (if_wr) begin
            if_id.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic              aclk,
    input  logic              rst,
    input  logic              mem_wr,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::word_t   prdata,
    input  logic              pready,
    output logic              psel,
    output logic              penable,
    output logic              pwrite,
    output core_pkg::word_t   paddr,
    output core_pkg::word_t   pwdata,
    output logic              mem_busy,
    output core_pkg::fwd_t    mem_fwd,
    output core_pkg::mem_wb_t mem_wb
);
    import core_pkg::*;

    apb_state_e state;       // registered, IDLE or ACCESS
    apb_state_e phase;       // bus phase driven this cycle
    apb_state_e state_nxt;
    logic       mem_req;
    mem_wb_t    mem_wb_nxt;

    assign mem_req = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write);

    // a new request is in SETUP as soon as it reaches EX/MEM
    always_comb begin
        if (state == ACCESS) begin
            phase = ACCESS;
        end else if (mem_req) begin
            phase = SETUP;
        end else begin
            phase = IDLE;
        end
        case (phase)
            SETUP:   state_nxt = ACCESS;
            ACCESS:  state_nxt = pready ? IDLE : ACCESS;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // EX/MEM is frozen while busy, so address and data hold
    assign psel     = (phase != IDLE);
    assign penable  = (phase == ACCESS);
    assign pwrite   = ex_mem.mem_write;
    assign paddr    = ex_mem.result;
    assign pwdata   = ex_mem.store_data;
    assign mem_busy = (phase == SETUP) || (phase == ACCESS && !pready);

    assign mem_fwd.valid   = ex_mem.valid && ex_mem.reg_write && (ex_mem.dst != '0);
    assign mem_fwd.dst     = ex_mem.dst;
    assign mem_fwd.value   = ex_mem.result;
    assign mem_fwd.is_load = ex_mem.mem_read;

    always_comb begin
        mem_wb_nxt.valid     = ex_mem.valid;
        mem_wb_nxt.pc        = ex_mem.pc;
        mem_wb_nxt.result    = ex_mem.mem_read ? prdata : ex_mem.result;
        mem_wb_nxt.dst       = ex_mem.dst;
        mem_wb_nxt.reg_write = ex_mem.reg_write;
    end

    always_ff @(posedge aclk) begin
        mem_wb <= mem_wb_nxt;
        if (rst || !mem_wr) begin
            mem_wb.valid <= 1'b0;    // bubble while the access waits
        end
    end

endmodule

`default_nettype wire

//--- design/mips_core_top.sv
`default_nettype none

module mips_core_top (
    input  logic               aclk,
    input  logic               rst,
    output core_pkg::word_t    imem_addr,
    input  core_pkg::instr_t   imem_rdata,
    output logic               psel,
    output logic               penable,
    output logic               pwrite,
    output core_pkg::word_t    paddr,
    output core_pkg::word_t    pwdata,
    input  core_pkg::word_t    prdata,
    input  logic               pready,
    output core_pkg::word_t    debug_wb_pc,
    output core_pkg::word_t    debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output core_pkg::reg_idx_t debug_wb_rf_wnum
);
    import core_pkg::*;

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    fwd_t    ex_fwd;
    fwd_t    mem_fwd;
    word_t   branch_target;
    logic    branch_taken;
    logic    load_stall;
    logic    mem_busy;
    logic    pc_wr;
    logic    if_wr;
    logic    id_wr;
    logic    ex_wr;
    logic    mem_wr;
    logic    if_flush;
    logic    id_flush;

    // golden trace from the MEM/WB register
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wdata = mem_wb.result;
    assign debug_wb_rf_wnum  = mem_wb.dst;
    assign debug_wb_rf_wen   = (mem_wb.valid && mem_wb.reg_write && mem_wb.dst != '0) ?
                               4'b1111 : 4'b0000;

    pipe_control u_pipe_control (
        .*
    );

    fetch_stage u_fetch_stage (
        .*
    );

    decode_stage u_decode_stage (
        .wb (mem_wb),
        .*
    );

    execute_stage u_execute_stage (
        .*
    );

    mem_stage u_mem_stage (
        .*
    );

endmodule

`default_nettype wire

//--- design/pipe_control.sv
`default_nettype none

module pipe_control (
    input  logic load_stall,
    input  logic branch_taken,
    input  logic mem_busy,
    output logic pc_wr,
    output logic if_wr,
    output logic id_wr,
    output logic ex_wr,
    output logic mem_wr,
    output logic if_flush,
    output logic id_flush
);

    always_comb begin
        pc_wr    = 1'b1;
        if_wr    = 1'b1;
        id_wr    = 1'b1;
        ex_wr    = 1'b1;
        mem_wr   = 1'b1;
        if_flush = 1'b0;
        id_flush = 1'b0;
        if (mem_busy) begin
            // whole front end waits on the APB completer
            pc_wr  = 1'b0;
            if_wr  = 1'b0;
            id_wr  = 1'b0;
            ex_wr  = 1'b0;
            mem_wr = 1'b0;           // MEM/WB takes a bubble
        end else if (branch_taken) begin
            if (load_stall) begin
                if_wr    = 1'b0;     // keep the stalled delay slot
                id_flush = 1'b1;
            end else begin
                if_flush = 1'b1;     // drop the wrong-path fetch
            end
        end else if (load_stall) begin
            pc_wr    = 1'b0;
            if_wr    = 1'b0;
            id_flush = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`default_nettype none

module reg_file (
    input  logic               aclk,
    input  logic               rst,
    input  core_pkg::mem_wb_t  wb,
    input  core_pkg::reg_idx_t ra_idx,
    input  core_pkg::reg_idx_t rb_idx,
    output core_pkg::word_t    ra_data,
    output core_pkg::word_t    rb_data
);
    import core_pkg::*;

    word_t regs [32];
    logic  we;

    assign we = wb.valid && wb.reg_write && (wb.dst != '0);

    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb.dst] <= wb.result;
        end
    end

    // write-back of this cycle is seen by the read
    always_comb begin
        if (ra_idx == '0) begin
            ra_data = '0;
        end else if (we && wb.dst == ra_idx) begin
            ra_data = wb.result;
        end else begin
            ra_data = regs[ra_idx];
        end
        if (rb_idx == '0) begin
            rb_data = '0;
        end else if (we && wb.dst == rb_idx) begin
            rb_data = wb.result;
        end else begin
            rb_data = regs[rb_idx];
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+design
design/core_pkg.sv
design/pipe_control.sv
design/fetch_stage.sv
design/reg_file.sv
design/decode_stage.sv
design/execute_stage.sv
design/mem_stage.sv
design/mips_core_top.sv
tb/tb_clock.sv
tb/tb_top.sv

//--- tb/core_patterns.hex
// program: word count, then instruction words from the reset pc, four per line
// trace: record count, then one record per line as pc, register number, data
00000028
3c011234 34215678 2402fffd 00221821 // lui, ori, addiu, addu
00612023 00812826 00a33024 00c23825 // subu, xor, and, or
0041402a 0022482a 00210021 00085021 // slt, slt, addu to $0, addu reading $0
340c0100 ad810000 ad850004 8d8d0000 // base, sw, sw, lw
01ad7021 8d8f0004 341000ff 01f08826 // load use, lw, ori, use one apart
11a10002 24120011 24130022 15a10002 // beq taken, slot, wrong path, bne not taken
24130033 24140044 16930002 26950001 // slot, addiu, bne taken, slot
24160055 8d980004 10000002 0301c821 // wrong path, lw, beq taken, load-stalled slot
241a0077 032ad823 ad9b0008 8d9c0008 // wrong path, subu, sw, lw
0380e821 0000f025 1000ffff 00000000 // load use, or of $0, self loop, slot
0000001b
bfc00000 00000001 12340000
bfc00004 00000001 12345678
bfc00008 00000002 fffffffd
bfc0000c 00000003 12345675
bfc00010 00000004 fffffffd
bfc00014 00000005 edcba985
bfc00018 00000006 00000005
bfc0001c 00000007 fffffffd
bfc00020 00000008 00000001
bfc00024 00000009 00000000
bfc0002c 0000000a 00000001
bfc00030 0000000c 00000100
bfc0003c 0000000d 12345678
bfc00040 0000000e 2468acf0
bfc00044 0000000f edcba985
bfc00048 00000010 000000ff
bfc0004c 00000011 edcba97a
bfc00054 00000012 00000011
bfc00060 00000013 00000033
bfc00064 00000014 00000044
bfc0006c 00000015 00000045
bfc00074 00000018 edcba985
bfc0007c 00000019 fffffffd
bfc00084 0000001b fffffffc
bfc0008c 0000001c fffffffc
bfc00090 0000001d fffffffc
bfc00094 0000001e 00000000

//--- tb/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // period of 20
    always #10 clk = ~clk;

endmodule

`default_nettype wire

//--- tb/tb_top.sv
`default_nettype none

`include "core_cfg.svh"

module tb_top;
    import core_pkg::*;

    logic        aclk;
    logic        rst;
    word_t       imem_addr;
    instr_t      imem_rdata;
    logic        psel;
    logic        penable;
    logic        pwrite;
    word_t       paddr;
    word_t       pwdata;
    word_t       prdata;
    logic        pready;
    word_t       debug_wb_pc;
    word_t       debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    reg_idx_t    debug_wb_rf_wnum;

    logic [31:0] pat [0:255];        // raw words of the pattern file
    instr_t      rom [0:63];
    int          prog_len;
    int          rec_base;
    int          rec_cnt;

    word_t       dmem [0:63];
    logic        dmem_written [0:63];
    logic [5:0]  mem_idx;
    integer      seed;
    int          wait_left;          // wait states still to insert
    logic        in_access;
    logic        had_setup;
    word_t       setup_addr;
    word_t       setup_wdata;
    logic        setup_write;
    int          xfer_cnt;
    int          apb_errs;
    int          tests_failed;
    int          total_errs;

    tb_clock clk_gen (
        .clk (aclk)
    );

    mips_core_top dut0 (
        .*
    );

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] exp, inout int errs);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errs++;
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs != 0) begin
            tests_failed++;
        end
        total_errs += errs;
        $display("test %s: %s, %0d error(s)", name, (errs == 0) ? "pass" : "FAIL", errs);
    endtask

    // wait for the next write-back record, bounded
    task automatic wait_retire(input int limit, output logic seen);
        int cyc;
        cyc = 0;
        while (debug_wb_rf_wen == 4'h0 && cyc < limit) begin
            @(negedge aclk);
            cyc++;
        end
        seen = (debug_wb_rf_wen != 4'h0);
    endtask

    function automatic instr_t rom_word(word_t addr);
        word_t offset;
        offset = addr - `CORE_RESET_PC;
        if (offset[1:0] == 2'b00 && (offset >> 2) < prog_len) begin
            return rom[offset[7:2]];
        end
        return '0;                   // nop outside the program
    endfunction

    // unwritten words read back a value made from the full address
    function automatic word_t dmem_fill(word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h5a5a_5a5a;
    endfunction

    // instruction ROM, answers the current pc within the cycle
    always @(posedge aclk) begin
        #1;
        imem_rdata = rom_word(imem_addr);
    end

    // APB completer with random wait states
    always @(posedge aclk) begin
        #1;
        pready = 1'b0;
        if (rst) begin
            in_access = 1'b0;
            had_setup = 1'b0;
        end else begin
            if (penable && !psel) begin
                $display("APB penable is high while psel is low");
                apb_errs++;
            end
            if (psel && !penable) begin
                had_setup   = 1'b1;
                in_access   = 1'b0;
                setup_addr  = paddr;
                setup_wdata = pwdata;
                setup_write = pwrite;
            end else if (psel && penable) begin
                if (!in_access) begin
                    if (!had_setup) begin
                        $display("APB access phase started without a setup phase");
                        apb_errs++;
                    end
                    in_access = 1'b1;
                    wait_left = $random(seed) & 3;
                end
                check("paddr", paddr, setup_addr, apb_errs);   // held since setup
                check("pwrite", pwrite, setup_write, apb_errs);
                check("pwdata", pwdata, setup_wdata, apb_errs);
                if (wait_left == 0) begin
                    pready  = 1'b1;
                    mem_idx = paddr[7:2];
                    if (pwrite) begin
                        dmem[mem_idx]         = pwdata;
                        dmem_written[mem_idx] = 1'b1;
                    end else begin
                        prdata = dmem_written[mem_idx] ? dmem[mem_idx] : dmem_fill(paddr);
                    end
                    xfer_cnt++;
                    in_access = 1'b0;
                    had_setup = 1'b0;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin
        logic        seen;
        int          reset_errs;
        int          trace_errs;
        int          drain_errs;
        int          r;
        int          cyc;
        logic [31:0] exp_pc;
        logic [31:0] exp_wnum;
        logic [31:0] exp_data;

        rst          = 1'b1;
        imem_rdata   = '0;
        prdata       = '0;
        pready       = 1'b0;
        seed         = 38;
        in_access    = 1'b0;
        had_setup    = 1'b0;
        xfer_cnt     = 0;
        apb_errs     = 0;
        tests_failed = 0;
        total_errs   = 0;
        for (int i = 0; i < 64; i++) begin
            dmem_written[i] = 1'b0;
        end

        $readmemh("tb/core_patterns.hex", pat);
        prog_len = pat[0];
        rec_base = prog_len + 2;
        rec_cnt  = pat[prog_len + 1];
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < prog_len) ? pat[1 + i] : '0;
        end

        repeat (5) @(posedge aclk);
        #1;
        rst = 1'b0;

        if ($isunknown(pat[0]) || prog_len > 64 || $isunknown(pat[prog_len + 1])) begin
            $display("pattern file tb/core_patterns.hex is missing or malformed");
            total_errs++;
        end else begin
            // bus and trace stay quiet until the first write-back
            reset_errs = 0;
            cyc = 0;
            @(negedge aclk);
            while (debug_wb_rf_wen == 4'h0 && cyc < 60) begin
                check("psel", psel, 1'b0, reset_errs);
                check("penable", penable, 1'b0, reset_errs);
                @(negedge aclk);
                cyc++;
            end
            if (debug_wb_rf_wen == 4'h0) begin
                $display("no instruction retired within %0d cycles after reset", cyc);
                reset_errs++;
            end
            report_test("reset idle", reset_errs);

            trace_errs = 0;
            for (r = 0; r < rec_cnt; r++) begin
                exp_pc   = pat[rec_base + 3 * r];
                exp_wnum = pat[rec_base + 3 * r + 1];
                exp_data = pat[rec_base + 3 * r + 2];
                if (r > 0) begin
                    @(negedge aclk);         // each record shows for one cycle
                end
                wait_retire(60, seen);
                if (!seen) begin
                    $display("record %0d with pc %h did not retire in time", r, exp_pc);
                    trace_errs++;
                    break;
                end
                check("debug_wb_pc", debug_wb_pc, exp_pc, trace_errs);
                check("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_wnum, trace_errs);
                check("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data, trace_errs);
                check("debug_wb_rf_wen", debug_wb_rf_wen, 32'hf, trace_errs);
            end
            report_test("program trace", trace_errs);

            // final branch loop writes no register
            drain_errs = 0;
            for (cyc = 0; cyc < 40; cyc++) begin
                @(negedge aclk);
                check("debug_wb_rf_wen", debug_wb_rf_wen, 32'h0, drain_errs);
            end
            report_test("no extra retire", drain_errs);

            if (xfer_cnt == 0) begin
                $display("no APB transfer took place");
                apb_errs++;
            end
            report_test("apb handshake", apb_errs);
        end

        $display("%0d of 4 tests failed, %0d error(s) in total", tests_failed, total_errs);
        if (total_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
